// File: verilog/rename_pkg.sv
// rename slice package with register file sizes, tag types and the rob entry layout
package rename_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////
	localparam int ARF_SIZE  = 32;                   // architectural registers
	localparam int PRF_SIZE  = 40;                   // physical registers
	localparam int ROB_SIZE  = 16;                   // reorder buffer slots
	localparam int ZERO_ARN  = 31;                   // hardwired zero, never renamed
	localparam int XLEN      = 64;                   // datapath width
	localparam int FREE_SIZE = PRF_SIZE - ARF_SIZE;  // tags beyond the committed map

	////////////////////////////////////////////////////////////////////////////
	// tags and words
	////////////////////////////////////////////////////////////////////////////
	typedef logic [$clog2(ARF_SIZE)-1:0] arn_t;      // 5 bit arch reg number
	typedef logic [$clog2(PRF_SIZE)-1:0] prn_t;      // 6 bit phys tag
	typedef logic [$clog2(ROB_SIZE)-1:0] rob_idx_t;  // 4 bit rob slot
	typedef logic [XLEN-1:0]             word_t;     // result value

	// one rob slot, 13 bits
	typedef struct packed {
		arn_t dest_arn;                          // arch destination
		prn_t dest_prn;                          // new phys destination
		logic wr_en;                             // writes a destination
		logic done;                              // result came back on the bus
	} rob_entry_t;

endpackage

// File: verilog/rename_ifs.sv
// dispatch and retire bundles shared between the rename slice blocks
`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// dispatch side
////////////////////////////////////////////////////////////////////////////
interface dispatch_if import rename_pkg::*; ();
	logic     fire;         // dispatch accepted this cycle
	logic     writes_dest;  // dest is not the zero reg
	arn_t     dest_arn;     // arch destination
	prn_t     dest_prn;     // free list head, combinational
	rob_idx_t rob_idx;      // rob tail slot

	modport rename  (output fire, writes_dest, dest_arn, input dest_prn);
	modport alloc   (input fire, writes_dest, output dest_prn);
	modport rob     (input fire, writes_dest, dest_arn, dest_prn, output rob_idx);
	modport regfile (input fire, writes_dest, dest_prn);
endinterface

////////////////////////////////////////////////////////////////////////////
// retire side
////////////////////////////////////////////////////////////////////////////
interface retire_if import rename_pkg::*; ();
	logic  valid;  // head retires this cycle
	arn_t  arn;    // head arch destination
	prn_t  prn;    // head phys destination
	logic  wr_en;  // head writes a destination
	word_t value;  // prf read by prn

	modport rob     (output valid, arn, prn, wr_en);
	modport map     (input valid, arn, prn, wr_en);
	modport regfile (input prn, output value);
endinterface

// File: verilog/rename_stage.sv
// rename stage with the speculative map table, dispatch gating and dest remap
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; (
	input  logic clock,
	input  logic rst_n,
	input  logic dispatch_valid,     // dispatch strobe
	input  arn_t src_a_arn,
	input  arn_t src_b_arn,
	input  arn_t dest_arn,
	input  logic free_avail,         // free list not empty
	input  logic rob_full,
	output logic dispatch_ready,     // level, both resources present
	output prn_t src_a_prn,
	output prn_t src_b_prn,
	dispatch_if.rename disp
);

	prn_t rat [ARF_SIZE];            // speculative arch to phys map

	////////////////////////////////////////////////////////////////////////////
	// lookup and gating
	////////////////////////////////////////////////////////////////////////////
	assign dispatch_ready = free_avail && !rob_full;
	assign src_a_prn      = rat[src_a_arn];           // pre-edge map, no bypass
	assign src_b_prn      = rat[src_b_arn];

	assign disp.fire        = dispatch_valid && dispatch_ready;  // pulse while low is dropped
	assign disp.writes_dest = (dest_arn != arn_t'(ZERO_ARN));    // r31 never renamed
	assign disp.dest_arn    = dest_arn;

	////////////////////////////////////////////////////////////////////////////
	// map update
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < ARF_SIZE; i++) begin
				rat[i] <= prn_t'(i);                      // identity after reset
			end
		end else if (disp.fire && disp.writes_dest) begin
			rat[dest_arn] <= disp.dest_prn;               // take the free list head
		end
	end

	// zero reg entry holds its reset tag for the whole run
	a_zero_map_stable: assert property (
		@(posedge clock) disable iff (!rst_n)
		$stable(rat[ZERO_ARN])
	) else $error("rename_stage: map entry of r31 changed");

endmodule

// File: verilog/free_list.sv
// free list of physical tags kept as a circular queue
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
	input  logic clock,
	input  logic rst_n,
	dispatch_if.alloc disp,
	input  logic release_valid,   // tag freed by the retire map
	input  prn_t release_prn,
	output logic free_avail       // at least one tag left
);

	prn_t                          free_q [FREE_SIZE];  // tag storage
	logic [$clog2(FREE_SIZE)-1:0]  head;                // next tag to hand out
	logic [$clog2(FREE_SIZE)-1:0]  tail;                // next slot to refill
	logic [$clog2(FREE_SIZE):0]    count;               // tags held
	logic                          pop;
	logic                          push;

	assign pop  = disp.fire && disp.writes_dest;  // only renamed dests use a tag
	assign push = release_valid;

	assign disp.dest_prn = free_q[head];          // shown before the pop edge
	assign free_avail    = (count != 0);

	////////////////////////////////////////////////////////////////////////////
	// queue update
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < FREE_SIZE; i++) begin
				free_q[i] <= prn_t'(ARF_SIZE + i);    // 32 up to 39
			end
			head  <= '0;
			tail  <= '0;
			count <= ($clog2(FREE_SIZE)+1)'(FREE_SIZE);  // starts full
		end else begin
			if (push) begin
				free_q[tail] <= release_prn;          // append at tail
				tail         <= tail + 1'b1;          // power of two wrap
			end
			if (pop) begin
				head <= head + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;              // both or neither
			endcase
		end
	end

	// a release only follows a commit of a tag taken from here
	a_no_push_full: assert property (
		@(posedge clock) disable iff (!rst_n)
		release_valid |-> (count != FREE_SIZE)
	) else $error("free_list: release while full");

endmodule

// File: verilog/phys_regfile.sv
// physical register file with values, ready bits, result bus write and read ports
`timescale 1ns/1ps

module phys_regfile import rename_pkg::*; (
	input  logic  clock,
	input  logic  rst_n,
	dispatch_if.regfile disp,
	input  logic  cdb_valid,      // result bus strobe
	input  prn_t  cdb_tag,
	input  word_t cdb_value,
	input  prn_t  src_a_prn,
	input  prn_t  src_b_prn,
	output logic  src_a_ready,
	output logic  src_b_ready,
	retire_if.regfile ret
);

	word_t               prf_value [PRF_SIZE];  // register values
	logic [PRF_SIZE-1:0] prf_ready;             // value present
	logic                alloc_en;
	logic                cdb_wr;

	assign alloc_en = disp.fire && disp.writes_dest;
	assign cdb_wr   = cdb_valid && (cdb_tag != prn_t'(ZERO_ARN));  // r31 tag stays zero

	////////////////////////////////////////////////////////////////////////////
	// reads, combinational
	////////////////////////////////////////////////////////////////////////////
	assign src_a_ready = prf_ready[src_a_prn];  // old bits, no same cycle bypass
	assign src_b_ready = prf_ready[src_b_prn];
	assign ret.value   = prf_value[ret.prn];    // commit value of the head

	////////////////////////////////////////////////////////////////////////////
	// writes at the edge
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < PRF_SIZE; i++) begin
				prf_value[i] <= '0;                  // every reg reads zero
			end
			prf_ready <= '1;
		end else begin
			if (alloc_en) begin
				prf_ready[disp.dest_prn] <= 1'b0;    // new tag waits for its result
			end
			if (cdb_wr) begin
				prf_ready[cdb_tag] <= 1'b1;
				prf_value[cdb_tag] <= cdb_value;
			end
		end
	end

endmodule

// File: verilog/reorder_buffer.sv
// reorder buffer holding dispatched instructions in order until they retire
`timescale 1ns/1ps

module reorder_buffer import rename_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	dispatch_if.rob  disp,
	input  logic     cdb_valid,       // result bus strobe
	input  rob_idx_t cdb_rob_idx,     // slot the result belongs to
	output logic     rob_full,
	retire_if.rob    ret
);

	rob_entry_t                 rob_mem [ROB_SIZE];  // slot payload
	rob_idx_t                   head;                // oldest entry
	rob_idx_t                   tail;                // next free slot
	logic [$clog2(ROB_SIZE):0]  count;               // entries in flight
	rob_entry_t                 head_entry;
	rob_entry_t                 new_entry;
	logic                       retire;
	rob_idx_t                   cdb_off;             // distance from head

	////////////////////////////////////////////////////////////////////////////
	// status and head view
	////////////////////////////////////////////////////////////////////////////
	assign rob_full     = (count == ROB_SIZE);
	assign disp.rob_idx = tail;
	assign head_entry   = rob_mem[head];
	assign retire       = (count != 0) && head_entry.done;  // empty rob never commits

	assign ret.valid = retire;
	assign ret.arn   = head_entry.dest_arn;
	assign ret.prn   = head_entry.dest_prn;
	assign ret.wr_en = head_entry.wr_en;

	// entry written at the tail
	always_comb begin
		new_entry.dest_arn = disp.dest_arn;
		new_entry.dest_prn = disp.dest_prn;
		new_entry.wr_en    = disp.writes_dest;
		new_entry.done     = 1'b0;
	end

	assign cdb_off = cdb_rob_idx - head;  // wraps at 16

	////////////////////////////////////////////////////////////////////////////
	// slot payload
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (disp.fire) begin
			rob_mem[tail] <= new_entry;
		end
		if (cdb_valid) begin
			rob_mem[cdb_rob_idx].done <= 1'b1;  // marks done, commit next cycle
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (disp.fire) begin
				tail <= tail + 1'b1;
			end
			if (retire) begin
				head <= head + 1'b1;  // one per cycle, in order
			end
			case ({disp.fire, retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the result bus only writes back entries still in flight
	a_cdb_live_slot: assert property (
		@(posedge clock) disable iff (!rst_n)
		cdb_valid |-> ({1'b0, cdb_off} < count)
	) else $error("reorder_buffer: result bus hit an empty slot");

endmodule

// File: verilog/retire_map.sv
// retirement map table that frees the tag a committed destination replaces
`timescale 1ns/1ps

module retire_map import rename_pkg::*; (
	input  logic clock,
	input  logic rst_n,
	retire_if.map ret,
	output logic release_valid,  // one edge after the commit
	output prn_t release_prn     // superseded tag
);

	prn_t rrat [ARF_SIZE];       // committed arch to phys map
	logic commit_wr;

	assign commit_wr = ret.valid && ret.wr_en;  // r31 commits leave the map alone

	////////////////////////////////////////////////////////////////////////////
	// map and release strobe
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < ARF_SIZE; i++) begin
				rrat[i] <= prn_t'(i);            // identity, same as the rat
			end
			release_valid <= 1'b0;
		end else begin
			release_valid <= commit_wr;
			if (commit_wr) begin
				rrat[ret.arn] <= ret.prn;        // new mapping becomes architectural
			end
		end
	end

	// released tag, captured before the map entry is overwritten
	always_ff @(posedge clock) begin
		if (commit_wr) begin
			release_prn <= rrat[ret.arn];
		end
	end

endmodule

// File: verilog/rename_core.sv
// rename and retire slice top level, one thread and one instruction per cycle
`timescale 1ns/1ps

module rename_core import rename_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     dispatch_valid,
	input  arn_t     src_a_arn,
	input  arn_t     src_b_arn,
	input  arn_t     dest_arn,
	input  logic     cdb_valid,
	input  prn_t     cdb_tag,
	input  word_t    cdb_value,
	input  rob_idx_t cdb_rob_idx,
	output logic     dispatch_ready,
	output prn_t     src_a_prn,
	output prn_t     src_b_prn,
	output logic     src_a_ready,
	output logic     src_b_ready,
	output prn_t     dest_prn,
	output rob_idx_t rob_idx,
	output logic     commit_valid,
	output arn_t     commit_arn,
	output logic     commit_wr_en,
	output word_t    commit_value
);

	logic free_avail;     // free list to rename
	logic rob_full;       // rob to rename
	logic release_valid;  // retire map to free list
	prn_t release_prn;

	dispatch_if disp ();
	retire_if   ret ();

	////////////////////////////////////////////////////////////////////////////
	// rename side
	////////////////////////////////////////////////////////////////////////////
	rename_stage u_rename (
		.clock          (clock),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.src_a_arn      (src_a_arn),
		.src_b_arn      (src_b_arn),
		.dest_arn       (dest_arn),
		.free_avail     (free_avail),
		.rob_full       (rob_full),
		.dispatch_ready (dispatch_ready),
		.src_a_prn      (src_a_prn),
		.src_b_prn      (src_b_prn),
		.disp           (disp.rename)
	);

	free_list u_free (
		.clock         (clock),
		.rst_n         (rst_n),
		.disp          (disp.alloc),
		.release_valid (release_valid),
		.release_prn   (release_prn),
		.free_avail    (free_avail)
	);

	phys_regfile u_prf (
		.clock       (clock),
		.rst_n       (rst_n),
		.disp        (disp.regfile),
		.cdb_valid   (cdb_valid),
		.cdb_tag     (cdb_tag),
		.cdb_value   (cdb_value),
		.src_a_prn   (src_a_prn),   // lookups straight from the map
		.src_b_prn   (src_b_prn),
		.src_a_ready (src_a_ready),
		.src_b_ready (src_b_ready),
		.ret         (ret.regfile)
	);

	////////////////////////////////////////////////////////////////////////////
	// retire side
	////////////////////////////////////////////////////////////////////////////
	reorder_buffer u_rob (
		.clock       (clock),
		.rst_n       (rst_n),
		.disp        (disp.rob),
		.cdb_valid   (cdb_valid),
		.cdb_rob_idx (cdb_rob_idx),
		.rob_full    (rob_full),
		.ret         (ret.rob)
	);

	retire_map u_rrat (
		.clock         (clock),
		.rst_n         (rst_n),
		.ret           (ret.map),
		.release_valid (release_valid),
		.release_prn   (release_prn)
	);

	assign dest_prn     = disp.dest_prn;  // free list head
	assign rob_idx      = disp.rob_idx;   // rob tail
	assign commit_valid = ret.valid;
	assign commit_arn   = ret.arn;
	assign commit_wr_en = ret.wr_en;
	assign commit_value = ret.value;

endmodule

// File: sim/tb_checks.svh
// testbench compare tasks, error counters and bounded waits on the rename slice outputs
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam int WAIT_LIMIT = 64;  // cycles before a wait gives up

int checks   = 0;               // compares made
int errors   = 0;               // wrong values seen
int timeouts = 0;               // waits that ran out

////////////////////////////////////////////////////////////////////////////
// value compares
////////////////////////////////////////////////////////////////////////////
task automatic flag_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	errors++;
	$display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
endtask

task automatic check_prn(input string name, input prn_t got, input prn_t exp);
	checks++;
	if (got !== exp) flag_value(name, 64'(got), 64'(exp));
endtask

task automatic check_arn(input string name, input arn_t got, input arn_t exp);
	checks++;
	if (got !== exp) flag_value(name, 64'(got), 64'(exp));
endtask

task automatic check_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
	checks++;
	if (got !== exp) flag_value(name, 64'(got), 64'(exp));
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
	checks++;
	if (got !== exp) flag_value(name, got, exp);
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) flag_value(name, 64'(got), 64'(exp));
endtask

////////////////////////////////////////////////////////////////////////////
// bounded waits, entered and left on a falling edge
////////////////////////////////////////////////////////////////////////////
task automatic wait_ready(output bit ok);
	int n;
	ok = 1'b0;
	for (n = 0; n < WAIT_LIMIT; n++) begin
		if (dispatch_ready === 1'b1) begin  // level from registered state only
			ok = 1'b1;
			break;
		end
		@(negedge clock);
	end
	if (!ok) begin
		timeouts++;
		$display("dispatch_ready stayed low for %0d cycles, at %0t", WAIT_LIMIT, $time);
	end
endtask

task automatic wait_commit(output bit ok);
	int n;
	ok = 1'b0;
	for (n = 0; n < WAIT_LIMIT; n++) begin
		if (commit_valid === 1'b1) begin
			ok = 1'b1;
			break;
		end
		@(negedge clock);
	end
	if (!ok) begin
		timeouts++;
		$display("no commit within %0d cycles, at %0t", WAIT_LIMIT, $time);
	end
endtask

`endif

// File: sim/tb_rename_core.sv
// testbench for the rename and retire slice with directed rename, writeback and stall tests
`timescale 1ns/1ps

module tb_rename_core import rename_pkg::*; ();

	logic     clock = 1'b0;
	logic     rst_n;
	logic     dispatch_valid;
	arn_t     src_a_arn;
	arn_t     src_b_arn;
	arn_t     dest_arn;
	logic     cdb_valid;
	prn_t     cdb_tag;
	word_t    cdb_value;
	rob_idx_t cdb_rob_idx;
	logic     dispatch_ready;
	prn_t     src_a_prn;
	prn_t     src_b_prn;
	logic     src_a_ready;
	logic     src_b_ready;
	prn_t     dest_prn;
	rob_idx_t rob_idx;
	logic     commit_valid;
	arn_t     commit_arn;
	logic     commit_wr_en;
	word_t    commit_value;

	// reference state kept by the testbench
	prn_t     map_model [ARF_SIZE];  // expected speculative map
	prn_t     free_model [$];        // expected free tags, head first
	rob_idx_t rob_head;
	rob_idx_t rob_tail;
	arn_t     rob_arn [$];           // in flight, oldest first
	logic     rob_wr [$];
	prn_t     rob_new [$];           // tag given at dispatch
	prn_t     rob_old [$];           // tag it replaces

	`include "tb_checks.svh"

	always #4 clock = ~clock;        // 8 ns period

	rename_core uut (.*);

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic lookup_check(input arn_t a, input arn_t b, input logic ra, input logic rb);
		src_a_arn = a;
		src_b_arn = b;
		#1;
		check_prn("src_a_prn", src_a_prn, map_model[a]);
		check_prn("src_b_prn", src_b_prn, map_model[b]);
		check_bit("src_a_ready", src_a_ready, ra);
		check_bit("src_b_ready", src_b_ready, rb);
		@(negedge clock);
	endtask

	task automatic dispatch_op(input arn_t a, input arn_t b, input arn_t d);
		bit   ok;
		prn_t head_tag;
		wait_ready(ok);
		if (ok) begin
			head_tag       = (free_model.size() != 0) ? free_model[0] : '0;
			dispatch_valid = 1'b1;
			src_a_arn      = a;
			src_b_arn      = b;
			dest_arn       = d;
			#1;
			check_prn("src_a_prn", src_a_prn, map_model[a]);
			check_prn("src_b_prn", src_b_prn, map_model[b]);
			check_prn("dest_prn", dest_prn, head_tag);
			check_idx("rob_idx", rob_idx, rob_tail);
			rob_arn.push_back(d);
			rob_wr.push_back(d != arn_t'(ZERO_ARN));
			rob_new.push_back(head_tag);
			rob_old.push_back(map_model[d]);
			if (d != arn_t'(ZERO_ARN)) begin
				map_model[d] = free_model.pop_front();  // r31 keeps its tag
			end
			rob_tail = rob_tail + 1'b1;
			@(negedge clock);                        // accepted at the edge before
			dispatch_valid = 1'b0;
		end
	endtask

	task automatic write_result(input rob_idx_t idx, input prn_t tag, input word_t value);
		cdb_valid   = 1'b1;
		cdb_rob_idx = idx;
		cdb_tag     = tag;
		cdb_value   = value;
		@(negedge clock);
		cdb_valid   = 1'b0;                          // one cycle strobe
	endtask

	task automatic commit_front(input word_t value);
		bit ok;
		wait_commit(ok);
		if (ok) begin
			check_arn("commit_arn", commit_arn, rob_arn[0]);
			check_bit("commit_wr_en", commit_wr_en, rob_wr[0]);
			if (rob_wr[0]) check_word("commit_value", commit_value, value);
		end
		if (rob_wr[0]) free_model.push_back(rob_old[0]);  // superseded tag comes back
		void'(rob_arn.pop_front());
		void'(rob_wr.pop_front());
		void'(rob_new.pop_front());
		void'(rob_old.pop_front());
		rob_head = rob_head + 1'b1;
		@(negedge clock);                            // past the retire edge
	endtask

	task automatic drain_rob();
		word_t value;
		while (rob_arn.size() != 0) begin
			value = {$urandom, $urandom};
			write_result(rob_head, rob_wr[0] ? rob_new[0] : prn_t'(ZERO_ARN), value);
			commit_front(value);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////
	task automatic test_reset_state();
		int i;
		check_bit("dispatch_ready", dispatch_ready, 1'b1);
		check_bit("commit_valid", commit_valid, 1'b0);
		for (i = 0; i < ARF_SIZE; i++) begin
			lookup_check(arn_t'(i), arn_t'(ARF_SIZE - 1 - i), 1'b1, 1'b1);
		end
	endtask

	task automatic test_rename_chain();
		dispatch_op(3, 4, 1);                        // gets 32, slot 0
		dispatch_op(1, 5, 2);                        // gets 33, slot 1
		lookup_check(1, 2, 1'b0, 1'b0);              // both still waiting
	endtask

	task automatic test_writeback_commit();
		word_t v_old;
		word_t v_young;
		v_old   = {$urandom, $urandom};
		v_young = {$urandom, $urandom};
		write_result(rob_idx_t'(rob_head + 1), rob_new[1], v_young);
		repeat (4) begin
			check_bit("commit_valid", commit_valid, 1'b0);  // head not done yet
			@(negedge clock);
		end
		write_result(rob_head, rob_new[0], v_old);
		commit_front(v_old);
		commit_front(v_young);
		lookup_check(1, 2, 1'b1, 1'b1);
	endtask

	task automatic test_free_backpressure();
		int    i;
		bit    ok;
		prn_t  old_tag;
		word_t value;
		for (i = 0; i < FREE_SIZE; i++) begin
			dispatch_op(arn_t'(i % 4), arn_t'(i + 1), arn_t'(i + 3));
		end
		check_bit("dispatch_ready", dispatch_ready, 1'b0);  // free list empty
		old_tag = rob_old[0];
		value   = {$urandom, $urandom};
		write_result(rob_head, rob_new[0], value);
		commit_front(value);
		wait_ready(ok);
		if (ok) check_prn("dest_prn", dest_prn, old_tag);
		dispatch_op(5, 6, 11);
		drain_rob();
	endtask

	task automatic test_rob_backpressure();
		int   i;
		prn_t head_tag;
		head_tag = free_model[0];
		for (i = 0; i < ROB_SIZE; i++) begin
			dispatch_op(arn_t'(i), arn_t'(ZERO_ARN), arn_t'(ZERO_ARN));
		end
		check_bit("dispatch_ready", dispatch_ready, 1'b0);  // rob full
		check_prn("dest_prn", dest_prn, head_tag);          // no tag taken
		drain_rob();                                        // all commits with wr_en low
		check_bit("dispatch_ready", dispatch_ready, 1'b1);
	endtask

	initial begin
		void'($urandom(32'h51f0));
		rst_n          = 1'b0;
		dispatch_valid = 1'b0;
		src_a_arn      = '0;
		src_b_arn      = '0;
		dest_arn       = '0;
		cdb_valid      = 1'b0;
		cdb_tag        = '0;
		cdb_value      = '0;
		cdb_rob_idx    = '0;
		rob_head       = '0;
		rob_tail       = '0;
		for (int i = 0; i < ARF_SIZE; i++) map_model[i] = prn_t'(i);
		for (int i = 0; i < FREE_SIZE; i++) free_model.push_back(prn_t'(ARF_SIZE + i));
		repeat (10) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		test_reset_state();
		test_rename_chain();
		test_writeback_commit();
		test_free_backpressure();
		test_rob_backpressure();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: compile.f
+incdir+sim
verilog/rename_pkg.sv
verilog/rename_ifs.sv
verilog/rename_stage.sv
verilog/free_list.sv
verilog/phys_regfile.sv
verilog/reorder_buffer.sv
verilog/retire_map.sv
verilog/rename_core.sv
sim/tb_rename_core.sv

// File: run_sim.sh
#!/bin/sh
# builds the rename slice testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rename_core -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_rename_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi
exit 0
